// ==== logic/motion_params.svh ====
`ifndef MOTION_PARAMS_SVH
`define MOTION_PARAMS_SVH

`define MOTION_ADR_W    4
`define MOTION_DATA_W   32
`define MOTION_AXES     2

// Word addresses
`define REG_CTRL        4'd0
`define REG_DT          4'd1
`define REG_STEPS       4'd2
`define REG_VEL0        4'd3
`define REG_VEL1        4'd4
`define REG_PULSE       4'd5
`define REG_STATUS      4'd6
`define REG_POS0        4'd7
`define REG_POS1        4'd8
`define REG_START       4'd9

// Control word bits
`define CTRL_EN0        0
`define CTRL_EN1        1
`define CTRL_INV0       2
`define CTRL_INV1       3
`define CTRL_ABORT_EN   4
`define CTRL_ES_POL     5   // 1 means active high

// Status word bits
`define ST_BUSY         0
`define ST_DONE         1
`define ST_ABORTED      2
`define ST_ENDSTOP      3

`define STEP_SETUP_CYCLES 2 // Dir to step setup time
`define ES_DEBOUNCE     4

`endif

// ==== logic/motion_pkg.sv ====
`include "motion_params.svh"

package motion_pkg;

    typedef logic [`MOTION_DATA_W-1:0] word_t;

    typedef logic [`MOTION_ADR_W-1:0] reg_adr_t;

    // Fraction of a step per tick, scaled by 2^32
    typedef logic signed [`MOTION_DATA_W-1:0] velocity_t;

    typedef logic [`MOTION_DATA_W-1:0] phase_t;

    typedef logic signed [`MOTION_DATA_W-1:0] position_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } tick_state_t;

endpackage

// ==== logic/motion_regs.sv ====
`timescale 1ns/1ns
`include "motion_params.svh"

module motion_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  motion_pkg::reg_adr_t     wb_adr,
    input  motion_pkg::word_t        wb_wdata,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     abort,
    input  logic                     es_level,
    input  motion_pkg::position_t    pos0,
    input  motion_pkg::position_t    pos1,
    output motion_pkg::word_t        wb_rdata,
    output logic                     wb_ack,
    output motion_pkg::word_t        dt,
    output motion_pkg::word_t        steps,
    output motion_pkg::velocity_t    vel0,
    output motion_pkg::velocity_t    vel1,
    output motion_pkg::word_t        pulse_n,
    output logic                     start,
    output logic                     abort_en,
    output logic                     es_pol,
    output logic                     irq,
    output logic [`MOTION_AXES-1:0]  ctrl_inv,
    output logic [`MOTION_AXES-1:0]  axis_en
);

    motion_pkg::word_t ctrl;
    motion_pkg::word_t status;
    motion_pkg::word_t rd_mux;
    logic              done_st;
    logic              aborted_st;
    logic              req;
    logic              wr_en;

    assign req   = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en = wb_cyc & wb_stb & wb_we & wb_ack; // Commit in the ack cycle

    always_comb begin
        status                = '0;
        status[`ST_BUSY]      = busy;
        status[`ST_DONE]      = done_st;
        status[`ST_ABORTED]   = aborted_st;
        status[`ST_ENDSTOP]   = es_level;
    end

    always_comb begin
        case (wb_adr)
            `REG_CTRL:   rd_mux = ctrl;
            `REG_DT:     rd_mux = dt;
            `REG_STEPS:  rd_mux = steps;
            `REG_VEL0:   rd_mux = vel0;
            `REG_VEL1:   rd_mux = vel1;
            `REG_PULSE:  rd_mux = pulse_n;
            `REG_STATUS: rd_mux = status;
            `REG_POS0:   rd_mux = pos0;
            `REG_POS1:   rd_mux = pos1;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_rdata <= '0;
        end else begin
            wb_ack <= req;
            if (req) begin
                wb_rdata <= rd_mux;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl    <= '0;
            dt      <= '0;
            steps   <= '0;
            vel0    <= '0;
            vel1    <= '0;
            pulse_n <= '0;
            start   <= 1'b0;
        end else begin
            start <= wr_en && (wb_adr == `REG_START);
            if (wr_en) begin
                case (wb_adr)
                    `REG_CTRL:  ctrl    <= wb_wdata;
                    `REG_DT:    dt      <= wb_wdata;
                    `REG_STEPS: steps   <= wb_wdata;
                    `REG_VEL0:  vel0    <= wb_wdata;
                    `REG_VEL1:  vel1    <= wb_wdata;
                    `REG_PULSE: pulse_n <= wb_wdata;
                    default: ;          // Read-only or strobe
                endcase
            end
        end
    end

    // New event wins over a clear of the sticky flags
    always_ff @(posedge clk) begin
        if (rst) begin
            done_st    <= 1'b0;
            aborted_st <= 1'b0;
        end else begin
            if (wr_en && (wb_adr == `REG_STATUS)) begin
                done_st    <= 1'b0;
                aborted_st <= 1'b0;
            end
            if (done) done_st <= 1'b1;
            if (abort && busy) aborted_st <= 1'b1;
        end
    end

    assign irq      = done_st | aborted_st;
    assign axis_en  = {ctrl[`CTRL_EN1], ctrl[`CTRL_EN0]};
    assign ctrl_inv = {ctrl[`CTRL_INV1], ctrl[`CTRL_INV0]};
    assign abort_en = ctrl[`CTRL_ABORT_EN];
    assign es_pol   = ctrl[`CTRL_ES_POL];

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

// ==== logic/step_tick_gen.sv ====
`timescale 1ns/1ns

module step_tick_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               abort,
    input  motion_pkg::word_t  dt,
    input  motion_pkg::word_t  steps,
    output logic               tick,
    output logic               busy,
    output logic               done
);

    motion_pkg::tick_state_t state;
    motion_pkg::word_t       dt_q;      // Period of the running move
    motion_pkg::word_t       per_cnt;
    motion_pkg::word_t       remain;    // Ticks still to issue

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= motion_pkg::IDLE;
            tick    <= 1'b0;
            dt_q    <= '0;
            per_cnt <= '0;
            remain  <= '0;
        end else begin
            tick <= 1'b0;
            case (state)
                motion_pkg::IDLE: begin
                    if (start) begin
                        state   <= motion_pkg::RUN;
                        dt_q    <= dt;
                        remain  <= steps;
                        per_cnt <= motion_pkg::word_t'(1);
                    end
                end
                motion_pkg::RUN: begin
                    if (abort) begin
                        state <= motion_pkg::IDLE;      // No done on abort
                    end else if (remain == '0) begin
                        state <= motion_pkg::FINISH;
                    end else if (per_cnt >= dt_q) begin
                        tick    <= 1'b1;
                        remain  <= remain - 1'b1;
                        per_cnt <= motion_pkg::word_t'(1);
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                    end
                end
                motion_pkg::FINISH: state <= motion_pkg::IDLE;
                default:            state <= motion_pkg::IDLE;
            endcase
        end
    end

    assign busy = (state == motion_pkg::RUN);
    assign done = (state == motion_pkg::FINISH);

    a_tick_in_run: assert property (@(posedge clk) disable iff (rst)
        tick |-> state == motion_pkg::RUN);

endmodule

// ==== logic/axis_rate_gen.sv ====
`timescale 1ns/1ns

module axis_rate_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   tick,
    input  logic                   enable,
    input  logic                   invert,
    input  motion_pkg::velocity_t  vel,
    output logic                   step_req,
    output logic                   step_dir,
    output motion_pkg::position_t  pos
);

    motion_pkg::phase_t phase;
    motion_pkg::phase_t mag;
    logic [32:0]        sum;        // Carry out is the step
    logic               neg;

    assign neg = vel[31];

    always_comb begin
        mag = neg ? motion_pkg::phase_t'(-vel) : motion_pkg::phase_t'(vel);
        sum = {1'b0, phase} + {1'b0, mag};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= '0;
            step_req <= 1'b0;
            step_dir <= 1'b0;
            pos      <= '0;
        end else begin
            step_req <= 1'b0;
            if (start) begin
                phase <= '0;
            end else if (tick && enable) begin
                phase    <= sum[31:0];
                step_req <= sum[32];
                step_dir <= ~neg ^ invert;  // Pin level, high for forward
                // Logical position ignores the pin invert
                if (sum[32]) begin
                    pos <= neg ? pos - motion_pkg::position_t'(1)
                               : pos + motion_pkg::position_t'(1);
                end
            end
        end
    end

endmodule

// ==== logic/step_pulse_gen.sv ====
`timescale 1ns/1ns
`include "motion_params.svh"

module step_pulse_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               step_req,
    input  logic               step_dir,
    input  motion_pkg::word_t  pulse_n,
    output logic               step,
    output logic               dir
);

    logic              setup;   // Waiting out dir setup time
    motion_pkg::word_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            setup <= 1'b0;
            step  <= 1'b0;
            dir   <= 1'b0;
            cnt   <= '0;
        end else if (step_req) begin
            dir   <= step_dir;
            setup <= 1'b1;
            cnt   <= motion_pkg::word_t'(`STEP_SETUP_CYCLES - 1);
        end else if (setup) begin
            if (cnt == '0) begin
                setup <= 1'b0;
                step  <= 1'b1;
                // Zero width behaves as one cycle
                cnt   <= (pulse_n == '0) ? '0 : pulse_n - 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (step) begin
            if (cnt == '0) begin
                step <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Tick period must cover setup plus pulse width
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        step_req |-> !setup && !step);

endmodule

// ==== logic/endstop_guard.sv ====
`timescale 1ns/1ns
`include "motion_params.svh"

module endstop_guard (
    input  logic  clk,
    input  logic  rst,
    input  logic  endstop,
    input  logic  es_pol,
    input  logic  abort_en,
    output logic  es_level,
    output logic  abort
);

    localparam int DB_W = $clog2(`ES_DEBOUNCE + 1);

    logic            sync_a;
    logic            sync_b;
    logic [DB_W-1:0] db_cnt;

    // Two-flop synchronizer on the async pin
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_a <= 1'b0;
            sync_b <= 1'b0;
        end else begin
            sync_a <= endstop;
            sync_b <= sync_a;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            es_level <= 1'b0;
            db_cnt   <= '0;
        end else if (sync_b == es_level) begin
            db_cnt <= '0;                       // Glitch restarts the count
        end else if (db_cnt == DB_W'(`ES_DEBOUNCE - 1)) begin
            es_level <= sync_b;
            db_cnt   <= '0;
        end else begin
            db_cnt <= db_cnt + 1'b1;
        end
    end

    assign abort = abort_en & (es_level == es_pol);

endmodule

// ==== logic/motion_top.sv ====
`timescale 1ns/1ns
`include "motion_params.svh"

module motion_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  motion_pkg::reg_adr_t     wb_adr,
    input  motion_pkg::word_t        wb_wdata,
    output motion_pkg::word_t        wb_rdata,
    output logic                     wb_ack,
    input  logic                     endstop,
    output logic [`MOTION_AXES-1:0]  mot_step,
    output logic [`MOTION_AXES-1:0]  mot_dir,
    output logic [`MOTION_AXES-1:0]  mot_enable,
    output logic                     irq
);

    motion_pkg::word_t      dt;
    motion_pkg::word_t      steps;
    motion_pkg::word_t      pulse_n;
    motion_pkg::velocity_t  vel0;
    motion_pkg::velocity_t  vel1;
    motion_pkg::position_t  pos0;
    motion_pkg::position_t  pos1;
    logic                   start;
    logic                   tick;
    logic                   busy;
    logic                   done;
    logic                   abort;
    logic                   abort_en;
    logic                   es_pol;
    logic                   es_level;
    logic [`MOTION_AXES-1:0] ctrl_inv;
    logic [`MOTION_AXES-1:0] axis_en;
    logic [`MOTION_AXES-1:0] step_req;
    logic [`MOTION_AXES-1:0] step_dir;

    assign mot_enable = ~axis_en;   // Driver enable is active low

    motion_regs i_motion_regs (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .busy(busy), .done(done), .abort(abort), .es_level(es_level),
        .pos0(pos0), .pos1(pos1),
        .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .dt(dt), .steps(steps), .vel0(vel0), .vel1(vel1), .pulse_n(pulse_n),
        .start(start), .abort_en(abort_en), .es_pol(es_pol), .irq(irq),
        .ctrl_inv(ctrl_inv), .axis_en(axis_en)
    );

    step_tick_gen i_step_tick_gen (
        .clk(clk), .rst(rst), .start(start), .abort(abort),
        .dt(dt), .steps(steps),
        .tick(tick), .busy(busy), .done(done)
    );

    endstop_guard i_endstop_guard (
        .clk(clk), .rst(rst), .endstop(endstop), .es_pol(es_pol),
        .abort_en(abort_en), .es_level(es_level), .abort(abort)
    );

    axis_rate_gen i_axis_rate_gen_0 (
        .clk(clk), .rst(rst), .start(start), .tick(tick),
        .enable(axis_en[0]), .invert(ctrl_inv[0]), .vel(vel0),
        .step_req(step_req[0]), .step_dir(step_dir[0]), .pos(pos0)
    );

    axis_rate_gen i_axis_rate_gen_1 (
        .clk(clk), .rst(rst), .start(start), .tick(tick),
        .enable(axis_en[1]), .invert(ctrl_inv[1]), .vel(vel1),
        .step_req(step_req[1]), .step_dir(step_dir[1]), .pos(pos1)
    );

    step_pulse_gen i_step_pulse_gen_0 (
        .clk(clk), .rst(rst), .step_req(step_req[0]), .step_dir(step_dir[0]),
        .pulse_n(pulse_n), .step(mot_step[0]), .dir(mot_dir[0])
    );

    step_pulse_gen i_step_pulse_gen_1 (
        .clk(clk), .rst(rst), .step_req(step_req[1]), .step_dir(step_dir[1]),
        .pulse_n(pulse_n), .step(mot_step[1]), .dir(mot_dir[1])
    );

endmodule

// ==== test/motion_tb.sv ====
`timescale 1ns/1ns
`include "motion_params.svh"

module motion_tb;

    localparam int BUS_TIMEOUT  = 20;
    localparam int MOVE_TIMEOUT = 4000;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    motion_pkg::reg_adr_t    wb_adr;
    motion_pkg::word_t       wb_wdata;
    motion_pkg::word_t       wb_rdata;
    logic                    wb_ack;
    logic                    endstop;
    logic [1:0]              mot_step;
    logic [1:0]              mot_dir;
    logic [1:0]              mot_enable;
    logic                    irq;

    int                      step_cnt[2];
    int                      width[2];
    int                      last_width[2];
    logic [1:0]              exp_dir;
    logic [1:0]              dir_chk;
    int                      move_cycles;
    logic [31:0]             rng = 32'hb05a;
    motion_pkg::velocity_t   vel_rand;
    motion_pkg::position_t   base_pos;
    motion_pkg::word_t       exp_steps;

    motion_top i_motion_top (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .endstop(endstop), .mot_step(mot_step), .mot_dir(mot_dir),
        .mot_enable(mot_enable), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run;
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic fail_value(input string name, input motion_pkg::word_t exp,
                              input motion_pkg::word_t got);
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
        stop_run();
    endtask

    task automatic fail_msg(input string what);
        $display("%0t ns %s", $time, what);
        stop_run();
    endtask

    task automatic check_eq(input string name, input motion_pkg::word_t exp,
                            input motion_pkg::word_t got);
        assert (got === exp) else fail_value(name, exp, got);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_access(input logic we, input motion_pkg::reg_adr_t adr,
                              input motion_pkg::word_t wdata,
                              output motion_pkg::word_t rdata);
        int n;
        n = 0;
        next_cycle();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        do begin
            next_cycle();
            n++;
            if (n > BUS_TIMEOUT) fail_msg("Wishbone access got no ack");
        end while (!wb_ack);
        rdata = wb_rdata;
        next_cycle();   // Hold the request through the ack edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input motion_pkg::reg_adr_t adr, input motion_pkg::word_t data);
        motion_pkg::word_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input motion_pkg::reg_adr_t adr, output motion_pkg::word_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic start_and_wait;
        int n;
        int idle;
        bus_write(`REG_STATUS, '0);
        bus_write(`REG_START, 32'd1);
        n = 0;
        while (!irq) begin
            next_cycle();
            n++;
            if (n > MOVE_TIMEOUT) fail_msg("Move never finished, irq stayed low");
        end
        move_cycles = n;
        // Last pulse trails irq by the setup time
        idle = 0;
        n = 0;
        while (idle < 8) begin
            next_cycle();
            idle = (mot_step == 2'b00) ? idle + 1 : 0;
            n++;
            if (n > MOVE_TIMEOUT) fail_msg("Step pins never went idle");
        end
    endtask

    task automatic wait_endstop(input logic level);
        next_cycle();
        endstop = level;
        // Synchronizer and debounce delay plus margin
        repeat (2 + `ES_DEBOUNCE + 2) next_cycle();
    endtask

    task automatic run_op(input logic [63:0] op, input motion_pkg::word_t a,
                          input motion_pkg::word_t b);
        motion_pkg::word_t rd;
        motion_pkg::word_t mag;
        motion_pkg::word_t pos_exp;
        logic [63:0]       prod;
        case (op)
            "wr":  bus_write(a[3:0], b);
            "rd": begin
                bus_read(a[3:0], rd);
                check_eq($sformatf("reg[%0d]", a), b, rd);
            end
            "st": begin
                bus_read(`REG_STATUS, rd);
                check_eq($sformatf("status[%0d]", a), b, rd[a[4:0]]);
            end
            "go":  start_and_wait();
            "es":  wait_endstop(a[0]);
            "clr": begin
                step_cnt   = '{0, 0};
                last_width = '{0, 0};
                dir_chk    = 2'b00;
            end
            "cnt": check_eq($sformatf("steps on axis %0d", a), b, step_cnt[a[0]]);
            "lt":  assert (step_cnt[a[0]] < b)
                   else fail_msg("Abort did not cut the step count short");
            "dir": begin
                exp_dir[a[0]] = b[0];
                dir_chk[a[0]] = 1'b1;
            end
            "en":  check_eq("mot_enable", a, mot_enable);
            "irq": check_eq("irq", a, irq);
            "pw":  check_eq($sformatf("step width axis %0d", a), b, last_width[a[0]]);
            "rv": begin
                rng      = lcg_next(rng);
                vel_rand = rng;
                mag      = vel_rand[31] ? -vel_rand : vel_rand;
                prod     = {32'b0, a} * {32'b0, mag};
                exp_steps = prod[63:32];    // Carries of N adds of |v|
                bus_read(`REG_POS0, base_pos);
                bus_write(`REG_VEL0, vel_rand);
                exp_dir[0] = ~vel_rand[31];
                dir_chk[0] = 1'b1;
            end
            "ck": begin
                check_eq("steps on axis 0", exp_steps, step_cnt[0]);
                pos_exp = vel_rand[31] ? base_pos - exp_steps : base_pos + exp_steps;
                bus_read(`REG_POS0, rd);
                check_eq("POS0", pos_exp, rd);
            end
            "cy":  assert (move_cycles < a)
                   else fail_msg("Aborted move ran for its full length");
            default: fail_msg("Unknown operation in the stimulus file");
        endcase
    endtask

    // Step edge monitor sampled away from the clock edge
    initial begin
        logic [1:0] prev;
        prev       = 2'b00;
        step_cnt   = '{0, 0};
        width      = '{0, 0};
        last_width = '{0, 0};
        forever begin
            @(posedge clk);
            #2;
            for (int i = 0; i < 2; i++) begin
                if (mot_step[i] && !prev[i]) begin
                    step_cnt[i]++;
                    width[i] = 1;
                    if (dir_chk[i]) begin
                        assert (mot_dir[i] == exp_dir[i])
                        else fail_value($sformatf("mot_dir[%0d]", i), exp_dir[i], mot_dir[i]);
                    end
                end else if (mot_step[i]) begin
                    width[i]++;
                end else if (prev[i]) begin
                    last_width[i] = width[i];
                end
            end
            prev = mot_step;
        end
    end

    initial begin
        int                fd;
        int                code;
        logic [63:0]       op;
        logic [8*128-1:0]  rest;
        motion_pkg::word_t a;
        motion_pkg::word_t b;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        endstop  = 1'b0;
        exp_dir  = 2'b00;
        dir_chk  = 2'b00;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = $fopen("test/motion_stim.txt", "r");
        if (fd == 0) fail_msg("Cannot open test/motion_stim.txt");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, b);
                if (code != 2) fail_msg("Malformed line in the stimulus file");
                run_op(op, a, b);
            end
        end
        $fclose(fd);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/motion_pkg.sv
logic/motion_regs.sv
logic/step_tick_gen.sv
logic/axis_rate_gen.sv
logic/step_pulse_gen.sv
logic/endstop_guard.sv
logic/motion_top.sv
test/motion_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the motion controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module motion_tb -o motion_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/motion_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== test/motion_stim.txt ====
# Columns: op, address or axis, data or expected value; numbers in hex
# Ops: wr rd st go es clr cnt lt dir en irq pw rv ck cy
en 3 0
# Register access
wr 0 3
wr 1 10
wr 2 28
wr 3 c0000000
wr 4 40000000
wr 5 3
rd 0 3
rd 1 10
rd 2 28
rd 3 c0000000
rd 4 40000000
rd 5 3
en 0 0
wr 0 1
rd 0 1
en 2 0
# Negative velocity, 3 cycle pulse
clr 0 0
dir 0 0
go 0 0
cnt 0 a
cnt 1 0
rd 7 fffffff6
rd 8 0
pw 0 3
# Inverted direction pin, 5 cycle pulse
wr 0 5
wr 5 5
clr 0 0
dir 0 1
go 0 0
cnt 0 a
rd 7 ffffffec
pw 0 5
# Random velocity on axis 0, axis 1 disabled
wr 0 1
clr 0 0
rv 28 0
go 0 0
ck 0 0
cnt 1 0
rd 8 0
# Sticky done and irq
st 1 1
irq 1 0
wr 6 0
st 1 0
irq 0 0
# Endstop abort, active high
wr 0 31
wr 3 40000000
es 1 0
clr 0 0
go 0 0
st 2 1
st 1 0
lt 0 a
cy 280 0
st 3 1
es 0 0
st 3 0
